//--- common/eeprom_pkg.sv
`default_nettype none

package eeprom_pkg;

    localparam int N_CHAN = 4;

    // serial controllers in the array, one bit each
    typedef logic [$clog2(N_CHAN)-1:0] chan_t;
    typedef logic [N_CHAN-1:0]         chan_vec_t;

    // 2k x 8 device, bits 10:8 ride in the control byte
    typedef logic [10:0] ee_addr_t;
    typedef logic [7:0]  ee_data_t;

    typedef logic [2:0] bit_cnt_t;     // bit position inside a byte

    localparam logic [3:0] DEV_CODE = 4'b1010;

    typedef enum logic [3:0]
    {
        IDLE,
        WRITE_START,
        CTRL_WRITE,
        ADDR_WRITE,
        DATA_WRITE,
        READ_START,     // repeated start before the read control byte
        CTRL_READ,
        DATA_READ,
        STOP,
        DONE
    } ctrl_state_t;

endpackage

`default_nettype wire

//--- hdl/eeprom_req_dispatch.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_req_dispatch
    import eeprom_pkg::*;
(
    input  wire            CLK,
    input  wire            RESET,
    input  wire            wr,
    input  wire            rd,
    input  wire chan_t     chan,
    input  wire ee_addr_t  addr,
    input  wire ee_data_t  wdata,
    input  wire chan_vec_t busy,
    output chan_vec_t      start_wr,
    output chan_vec_t      start_rd,
    output ee_addr_t       ch_addr [N_CHAN],
    output ee_data_t       ch_wdata [N_CHAN],
    output logic           req_drop
);

    chan_vec_t sel;
    chan_vec_t pend;
    logic      accept;

    assign sel    = chan_vec_t'(1) << chan;
    // a strobe still in flight counts as busy, the controller flag lags it
    assign pend   = busy | start_wr | start_rd;
    assign accept = (wr || rd) && !pend[chan];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            start_wr <= '0;
            start_rd <= '0;
            req_drop <= 1'b0;
        end
        else
        begin
            start_wr <= (accept && wr) ? sel : '0;
            start_rd <= (accept && !wr) ? sel : '0;   // write wins if both
            req_drop <= (wr || rd) && pend[chan];
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int k = 0; k < N_CHAN; k++)
        begin
            if (accept && sel[k])
            begin
                ch_addr[k]  <= addr;
                ch_wdata[k] <= wdata;
            end
        end
    end

endmodule

`default_nettype wire

//--- eeprom_ctrl/eeprom_serial_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_serial_ctrl
    import eeprom_pkg::*;
(
    input  wire           CLK,
    input  wire           RESET,
    input  wire           start_wr,
    input  wire           start_rd,
    input  wire ee_addr_t addr,
    input  wire ee_data_t wdata,
    input  wire           sda_in,
    output logic          scl,
    output logic          sda_oe,
    output logic          busy,
    output logic          done,
    output logic          was_read,
    output ee_data_t      rdata
);

    ctrl_state_t state;
    bit_cnt_t    bit_cnt;
    ee_data_t    sh;         // outgoing byte, msb first
    logic        ph;         // 0 drops scl, 1 moves data and raises scl
    logic        scl_d;
    logic        last_bit;

    assign last_bit = (bit_cnt == 3'd7);

    // scl lags the fsm by half a clock so sda always moves mid-phase
    always_ff @(negedge CLK)
    begin
        if (RESET)
            scl <= 1'b1;
        else
            scl <= scl_d;
    end

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            state    <= IDLE;
            ph       <= 1'b0;
            bit_cnt  <= '0;
            scl_d    <= 1'b1;
            sda_oe   <= 1'b0;
            busy     <= 1'b0;
            done     <= 1'b0;
            was_read <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            if (done)
                busy <= 1'b0;     // drops the cycle after done

            case (state)
                IDLE:
                begin
                    ph      <= 1'b0;
                    bit_cnt <= '0;
                    if (start_wr || start_rd)
                    begin
                        busy     <= 1'b1;
                        was_read <= start_rd;
                        state    <= WRITE_START;
                    end
                end

                WRITE_START:
                begin
                    sda_oe <= 1'b1;        // start, sda falls while scl high
                    sh     <= {DEV_CODE, addr[10:8], 1'b0};
                    state  <= CTRL_WRITE;
                end

                CTRL_WRITE, ADDR_WRITE, DATA_WRITE, CTRL_READ:
                begin
                    if (!ph)
                    begin
                        scl_d <= 1'b0;
                        ph    <= 1'b1;
                    end
                    else
                    begin
                        sda_oe  <= ~sh[7];     // open drain, a zero pulls low
                        sh      <= {sh[6:0], 1'b0};
                        scl_d   <= 1'b1;
                        ph      <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit)
                        begin
                            case (state)
                                CTRL_WRITE:
                                begin
                                    sh    <= addr[7:0];
                                    state <= ADDR_WRITE;
                                end
                                ADDR_WRITE:
                                begin
                                    sh    <= wdata;
                                    state <= was_read ? READ_START : DATA_WRITE;
                                end
                                CTRL_READ:
                                    state <= DATA_READ;
                                default:
                                    state <= STOP;
                            endcase
                        end
                    end
                end

                // bit_cnt doubles as the step count in READ_START and STOP
                READ_START:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    case (bit_cnt)
                        3'd0:
                            scl_d <= 1'b0;
                        3'd1:
                        begin
                            sda_oe <= 1'b0;    // release while scl low
                            scl_d  <= 1'b1;
                        end
                        default:
                        begin
                            sda_oe  <= 1'b1;   // repeated start
                            sh      <= {DEV_CODE, addr[10:8], 1'b1};
                            bit_cnt <= '0;
                            state   <= CTRL_READ;
                        end
                    endcase
                end

                DATA_READ:
                begin
                    if (!ph)
                    begin
                        scl_d <= 1'b0;
                        ph    <= 1'b1;
                    end
                    else
                    begin
                        sda_oe  <= 1'b0;
                        rdata   <= {rdata[6:0], sda_in};   // slave bit settled during scl low
                        scl_d   <= 1'b1;
                        ph      <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (last_bit)
                            state <= STOP;
                    end
                end

                STOP:
                begin
                    bit_cnt <= bit_cnt + 1'b1;
                    case (bit_cnt)
                        3'd0:
                            scl_d <= 1'b0;
                        3'd1:
                        begin
                            sda_oe <= 1'b1;
                            scl_d  <= 1'b1;
                        end
                        default:
                        begin
                            sda_oe  <= 1'b0;   // stop, sda rises while scl high
                            bit_cnt <= '0;
                            state   <= DONE;
                        end
                    endcase
                end

                DONE:
                begin
                    done  <= 1'b1;
                    state <= IDLE;
                end

                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/eeprom_resp_collect.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_resp_collect
    import eeprom_pkg::*;
(
    input  wire            CLK,
    input  wire            RESET,
    input  wire chan_vec_t done,
    input  wire chan_vec_t was_read,
    input  wire ee_data_t  rdata [N_CHAN],
    output logic           resp_valid,
    output chan_t          resp_chan,
    output logic           resp_read,
    output ee_data_t       resp_rdata
);

    chan_vec_t pend;
    chan_vec_t rd_flag;
    ee_data_t  rd_byte [N_CHAN];
    chan_t     ptr;          // first channel to look at
    chan_t     idx;
    chan_t     pick;
    logic      found;
    chan_vec_t clr;

    always_comb
    begin
        found = 1'b0;
        pick  = ptr;
        idx   = ptr;
        for (int i = 0; i < N_CHAN; i++)
        begin
            idx = ptr + chan_t'(i);    // wraps with chan_t
            if (!found && pend[idx])
            begin
                found = 1'b1;
                pick  = idx;
            end
        end
    end

    assign clr        = found ? (chan_vec_t'(1) << pick) : '0;
    assign resp_valid = found;
    assign resp_chan  = pick;
    assign resp_read  = rd_flag[pick];
    assign resp_rdata = rd_byte[pick];

    always_ff @(posedge CLK)
    begin
        if (RESET)
        begin
            pend <= '0;
            ptr  <= '0;
        end
        else
        begin
            pend <= (pend & ~clr) | done;
            if (found)
                ptr <= pick + 1'b1;
        end
    end

    always_ff @(posedge CLK)
    begin
        for (int k = 0; k < N_CHAN; k++)
        begin
            if (done[k])
            begin
                rd_byte[k] <= rdata[k];
                rd_flag[k] <= was_read[k];
            end
        end
    end

endmodule

`default_nettype wire

//--- hdl/eeprom_array_top.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_array_top
    import eeprom_pkg::*;
(
    input  wire            CLK,
    input  wire            RESET,
    input  wire            wr,
    input  wire            rd,
    input  wire chan_t     chan,
    input  wire ee_addr_t  addr,
    input  wire ee_data_t  wdata,
    input  wire chan_vec_t sda_in,
    output wire chan_vec_t scl,
    output wire chan_vec_t sda_oe,
    output wire            req_drop,
    output wire            resp_valid,
    output wire chan_t     resp_chan,
    output wire            resp_read,
    output wire ee_data_t  resp_rdata
);

    wire chan_vec_t start_wr;
    wire chan_vec_t start_rd;
    wire chan_vec_t busy;
    wire chan_vec_t done;
    wire chan_vec_t was_read;
    wire ee_addr_t  ch_addr [N_CHAN];
    wire ee_data_t  ch_wdata [N_CHAN];
    wire ee_data_t  rdata [N_CHAN];

    eeprom_req_dispatch i_dispatch (
        .CLK      (CLK),
        .RESET    (RESET),
        .wr       (wr),
        .rd       (rd),
        .chan     (chan),
        .addr     (addr),
        .wdata    (wdata),
        .busy     (busy),
        .start_wr (start_wr),
        .start_rd (start_rd),
        .ch_addr  (ch_addr),
        .ch_wdata (ch_wdata),
        .req_drop (req_drop)
    );

    // one independent two-wire bus per channel
    for (genvar k = 0; k < N_CHAN; k++)
    begin : g_ctrl
        eeprom_serial_ctrl i_ctrl (
            .CLK      (CLK),
            .RESET    (RESET),
            .start_wr (start_wr[k]),
            .start_rd (start_rd[k]),
            .addr     (ch_addr[k]),
            .wdata    (ch_wdata[k]),
            .sda_in   (sda_in[k]),
            .scl      (scl[k]),
            .sda_oe   (sda_oe[k]),
            .busy     (busy[k]),
            .done     (done[k]),
            .was_read (was_read[k]),
            .rdata    (rdata[k])
        );
    end

    eeprom_resp_collect i_collect (
        .CLK        (CLK),
        .RESET      (RESET),
        .done       (done),
        .was_read   (was_read),
        .rdata      (rdata),
        .resp_valid (resp_valid),
        .resp_chan  (resp_chan),
        .resp_read  (resp_read),
        .resp_rdata (resp_rdata)
    );

endmodule

`default_nettype wire

//--- dv/tb_clk_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clk_gen
(
    output logic CLK
);

    initial
        CLK = 1'b0;

    always #10 CLK = ~CLK;     // 20 ns period

endmodule

`default_nettype wire

//--- dv/eeprom_slave_model.sv
`timescale 1ns/1ns
`default_nettype none

module eeprom_slave_model
    import eeprom_pkg::*;
(
    input  wire  scl,
    input  wire  sda,
    output logic sda_low
);

    ee_data_t mem [2048];
    ee_data_t sh;
    ee_data_t obyte;
    logic [2:0] blk;
    logic [7:0] lo;
    int   bit_n;
    int   obit;
    int   phase;       // 0 control, 1 address, 2 data
    logic active;
    logic reading;

    initial
    begin
        sda_low = 1'b0;
        active  = 1'b0;
        reading = 1'b0;
        for (int i = 0; i < 2048; i++)
            mem[i] = ee_data_t'(i ^ (i >> 3) ^ 'h5a);
    end

    // start or repeated start
    always @(negedge sda)
    begin
        if (scl === 1'b1)
        begin
            active  = 1'b1;
            reading = 1'b0;
            bit_n   = 0;
            phase   = 0;
        end
    end

    always @(posedge sda)
    begin
        if (scl === 1'b1)
            active = 1'b0;     // stop
    end

    always @(posedge scl)
    begin
        if (active && !reading)
        begin
            sh = {sh[6:0], sda};
            bit_n++;
            if (bit_n == 8)
            begin
                bit_n = 0;
                if (phase == 0)
                begin
                    blk = sh[3:1];
                    if (sh[7:4] != DEV_CODE)
                        active = 1'b0;
                    else if (sh[0])
                    begin
                        reading = 1'b1;
                        obyte   = mem[{blk, lo}];
                        obit    = 0;
                    end
                    else
                        phase = 1;
                end
                else if (phase == 1)
                begin
                    lo    = sh;
                    phase = 2;
                end
                else
                begin
                    mem[{blk, lo}] = sh;
                    lo = lo + 1'b1;
                end
            end
        end
    end

    // read bits go out while scl is low, msb first
    always @(negedge scl)
    begin
        if (reading && obit < 8)
        begin
            sda_low = ~obyte[7 - obit];
            obit++;
        end
        else
        begin
            sda_low = 1'b0;
            reading = 1'b0;
        end
    end

endmodule

`default_nettype wire

//--- dv/tb_eeprom_array.sv
`timescale 1ns/1ns
`default_nettype none

module tb_eeprom_array
    import eeprom_pkg::*;
();

    localparam int RAND_SEED  = 7;
    localparam int N_RAND     = 40;
    localparam int N_TXN      = N_RAND + 16;   // directed transactions plus the random ones
    localparam int TXN_CYCLES = 120;    // worst case read plus collector delay

    wire        CLK;
    logic       RESET;
    logic       wr;
    logic       rd;
    chan_t      chan;
    ee_addr_t   addr;
    ee_data_t   wdata;
    wire chan_vec_t sda_in;
    wire chan_vec_t scl;
    wire chan_vec_t sda_oe;
    wire chan_vec_t slave_low;
    wire        req_drop;
    wire        resp_valid;
    wire chan_t resp_chan;
    wire        resp_read;
    wire ee_data_t resp_rdata;

    logic [10:0] resp_q [$];    // {chan, read flag, data}
    int          drop_cnt = 0;
    ee_data_t    shadow [N_CHAN][2048];

    tb_clk_gen i_clk_gen (.CLK(CLK));

    eeprom_array_top i_eeprom_array_top (
        .CLK        (CLK),
        .RESET      (RESET),
        .wr         (wr),
        .rd         (rd),
        .chan       (chan),
        .addr       (addr),
        .wdata      (wdata),
        .sda_in     (sda_in),
        .scl        (scl),
        .sda_oe     (sda_oe),
        .req_drop   (req_drop),
        .resp_valid (resp_valid),
        .resp_chan  (resp_chan),
        .resp_read  (resp_read),
        .resp_rdata (resp_rdata)
    );

    // wired-and bus where either side can pull low
    assign sda_in = ~(sda_oe | slave_low);

    for (genvar k = 0; k < N_CHAN; k++)
    begin : g_slave
        eeprom_slave_model i_slave (.scl(scl[k]), .sda(sda_in[k]), .sda_low(slave_low[k]));
    end

    always @(posedge CLK)
    begin
        if (!RESET && resp_valid)
            resp_q.push_back({resp_chan, resp_read, resp_rdata});
        if (!RESET && req_drop)
            drop_cnt++;
    end

    initial
    begin
        #((N_TXN * TXN_CYCLES + 500) * 20);
        $display("Simulation timed out before all tests finished");
        $display("*** FAILED ***");
        $fatal(1, "watchdog expired");
    end

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("Error: %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "value mismatch");
        end
    endtask

    task automatic drive_req(input logic is_wr, input chan_t ch, input ee_addr_t a,
                             input ee_data_t d);
        @(posedge CLK);
        wr    <= is_wr;
        rd    <= !is_wr;
        chan  <= ch;
        addr  <= a;
        wdata <= d;
    endtask

    task automatic end_req();
        @(posedge CLK);
        wr <= 1'b0;
        rd <= 1'b0;
    endtask

    task automatic wait_resp(output logic [10:0] r);
        while (resp_q.size() == 0)
            @(negedge CLK);
        r = resp_q.pop_front();
    endtask

    task automatic do_write(input string name, input chan_t ch, input ee_addr_t a,
                            input ee_data_t d);
        logic [10:0] r;
        drive_req(1'b1, ch, a, d);
        end_req();
        shadow[ch][a] = d;
        wait_resp(r);
        check_value({name, " chan"}, ch, r[10:9]);
        check_value({name, " read flag"}, 0, r[8]);
    endtask

    task automatic do_read(input string name, input chan_t ch, input ee_addr_t a);
        logic [10:0] r;
        drive_req(1'b0, ch, a, '0);
        end_req();
        wait_resp(r);
        check_value({name, " chan"}, ch, r[10:9]);
        check_value({name, " read flag"}, 1, r[8]);
        check_value({name, " data"}, shadow[ch][a], r[7:0]);
    endtask

    task automatic reset_test();
        @(negedge CLK);
        check_value("reset resp_valid", 0, resp_valid);
        check_value("reset req_drop", 0, req_drop);
        check_value("reset scl", 4'hf, scl);
        check_value("reset sda_oe", 0, sda_oe);
    endtask

    task automatic all_chan_test();
        logic [10:0] r;
        chan_vec_t   seen;
        for (int k = 0; k < N_CHAN; k++)
        begin
            drive_req(1'b1, chan_t'(k), 11'h0a0, ee_data_t'(8'h11 * (k + 1)));
            shadow[k][11'h0a0] = ee_data_t'(8'h11 * (k + 1));
        end
        end_req();
        seen = '0;
        for (int k = 0; k < N_CHAN; k++)
        begin
            wait_resp(r);
            check_value("all_chan write flag", 0, r[8]);
            seen[r[10:9]] = 1'b1;
        end
        check_value("all_chan write set", 4'hf, seen);
        for (int k = 0; k < N_CHAN; k++)
            drive_req(1'b0, chan_t'(k), 11'h0a0, '0);
        end_req();
        seen = '0;
        for (int k = 0; k < N_CHAN; k++)
        begin
            wait_resp(r);
            check_value("all_chan read flag", 1, r[8]);
            check_value("all_chan data", shadow[r[10:9]][11'h0a0], r[7:0]);
            seen[r[10:9]] = 1'b1;
        end
        check_value("all_chan read set", 4'hf, seen);
    endtask

    task automatic busy_drop_test();
        logic [10:0] r;
        int          drops_before;
        drops_before = drop_cnt;
        drive_req(1'b1, 2'd1, 11'h2f0, 8'h3c);
        drive_req(1'b1, 2'd1, 11'h2f0, 8'hc3);     // start strobe still in flight
        end_req();
        while (scl[1] !== 1'b0)                    // controller has started shifting
            @(negedge CLK);
        drive_req(1'b0, 2'd1, 11'h2f0, 8'h00);     // lands on a busy channel
        end_req();
        shadow[1][11'h2f0] = 8'h3c;
        wait_resp(r);
        check_value("busy_drop chan", 1, r[10:9]);
        check_value("busy_drop read flag", 0, r[8]);
        check_value("busy_drop pulses", drops_before + 2, drop_cnt);
        do_read("busy_drop read", 2'd1, 11'h2f0);
        repeat (200) @(negedge CLK);
        check_value("busy_drop extra", 0, resp_q.size());
    endtask

    task automatic random_test();
        logic [12:0] written [$];    // {chan, addr}
        logic [12:0] pick;
        chan_t       ch;
        for (int n = 0; n < N_RAND; n++)
        begin
            ch = chan_t'($urandom_range(N_CHAN - 1));
            if (written.size() > 0 && $urandom_range(1) == 1)
            begin
                pick = written[$urandom_range(written.size() - 1)];
                do_read("random read", pick[12:11], pick[10:0]);
            end
            else
            begin
                pick = {ch, ee_addr_t'($urandom)};
                do_write("random write", ch, pick[10:0], ee_data_t'($urandom));
                written.push_back(pick);
            end
        end
    endtask

    initial
    begin
        void'($urandom(RAND_SEED));
        RESET = 1'b1;
        wr    = 1'b0;
        rd    = 1'b0;
        chan  = '0;
        addr  = '0;
        wdata = '0;
        repeat (4) @(posedge CLK);
        RESET <= 1'b0;
        reset_test();
        do_write("write_read write", 2'd0, 11'h123, 8'ha5);
        do_read("write_read read", 2'd0, 11'h123);
        all_chan_test();
        // same low byte but different bits 10:8
        do_write("high_addr write lo", 2'd2, 11'h035, 8'h5e);
        do_write("high_addr write hi", 2'd2, 11'h535, 8'he5);
        do_read("high_addr read lo", 2'd2, 11'h035);
        do_read("high_addr read hi", 2'd2, 11'h535);
        busy_drop_test();
        random_test();
        check_value("total drops", 2, drop_cnt);
        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- all.f
common/eeprom_pkg.sv
hdl/eeprom_req_dispatch.sv
eeprom_ctrl/eeprom_serial_ctrl.sv
hdl/eeprom_resp_collect.sv
hdl/eeprom_array_top.sv
dv/tb_clk_gen.sv
dv/eeprom_slave_model.sv
dv/tb_eeprom_array.sv

//--- run_sim.sh
#!/bin/sh
# build and run the EEPROM array testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module tb_eeprom_array \
    -f all.f -o sim_eeprom_array

./obj_dir/sim_eeprom_array | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
    echo "simulation passed"
else
    echo "simulation failed"
    exit 1
fi
